//--- dv/instr_stimulus.txt
# opcode funct3 funct7 (hex), zero negative carry_out overflow, class, pc_src, wr_reg_src
# byte mask (hex, 00 without data access); class codes follow the instr_class_t order
33 0 00  0 0 0 0   0 0 0 00
33 1 20  0 0 0 0  11 0 0 00
3B 0 00  0 0 0 0   0 0 0 00
3B 2 00  0 0 0 0  11 0 0 00
13 0 00  0 0 0 0   1 0 0 00
13 5 20  0 0 0 0   1 0 0 00
13 1 40  0 0 0 0  11 0 0 00
1B 0 00  0 0 0 0   1 0 0 00
37 0 00  0 0 0 0   2 0 0 00
17 0 00  0 0 0 0   3 0 0 00
6F 0 00  0 0 0 0   4 1 3 00
67 0 00  0 0 0 0   5 1 3 00
63 0 00  1 0 0 0   6 1 0 00
63 1 00  1 0 0 0   6 0 0 00
63 4 00  0 1 0 0   6 1 0 00
63 5 00  0 1 0 1   6 1 0 00
63 6 00  0 0 1 0   6 0 0 00
63 7 00  0 0 0 0   6 0 0 00
03 0 00  0 0 0 0   7 0 2 01
03 3 00  0 0 0 0   7 0 2 FF
03 5 00  0 0 0 0   7 0 2 03
03 7 00  0 0 0 0  11 0 0 00
23 1 00  0 0 0 0   8 0 0 03
23 2 00  0 0 0 0   8 0 0 0F
23 4 00  0 0 0 0  11 0 0 00
0F 0 00  0 0 0 0   9 0 0 00
73 0 00  0 0 0 0  10 0 0 00
7F 0 00  0 0 0 0  11 0 0 00

//--- dv/rv_ctrl_tb.sv
module rv_ctrl_tb;
    import rv_ctrl_pkg::*;

    typedef struct packed {
        logic [OPCODE_W-1:0]  opcode;
        logic [FUNCT3_W-1:0]  funct3;
        logic [FUNCT7_W-1:0]  funct7;
        logic [3:0]           flags;  // zero, negative, carry_out, overflow
        logic [3:0]           cls;
        logic                 pc_src;
        logic [WR_SRC_W-1:0]  wr_src;
        logic [BYTE_EN_W-1:0] mask;
    } vector_t;

    logic                 clock;
    logic                 reset;
    logic                 mem_ack;
    logic [OPCODE_W-1:0]  opcode;
    logic [FUNCT3_W-1:0]  funct3;
    logic [FUNCT7_W-1:0]  funct7;
    logic                 zero, negative, carry_out, overflow;
    logic                 mem_rd_en, mem_wr_en;
    logic [BYTE_EN_W-1:0] mem_byte_en;
    logic                 alua_src, alub_src, aluy_src, sub, arithmetic, alupc_src;
    logic [ALU_OP_W-1:0]  alu_src;
    logic                 pc_src, pc_en, wr_reg_en, ir_en, mem_addr_src;
    logic [WR_SRC_W-1:0]  wr_reg_src;
    logic                 illegal_instruction, ecall;

    vector_t vectors[$];
    int      errors;
    bit      loaded;

    rv_ctrl_top u_dut (.*);

    always #2 clock = ~clock;

    task automatic report_error(input int idx, input string msg);
        errors++;
        $display("error %0t: vector %0d %s", $time, idx, msg);
    endtask

    function automatic logic any_strobe();
        return mem_rd_en | mem_wr_en | (|mem_byte_en) | pc_en | ir_en | wr_reg_en |
               illegal_instruction | ecall | alua_src | alub_src | aluy_src | (|alu_src) |
               sub | arithmetic | alupc_src | pc_src | (|wr_reg_src) | mem_addr_src;
    endfunction

    task automatic load_stimulus();
        int      fd;
        int      n;
        string   line;
        int      op, f3, f7, z, ng, c, ov, cls, pcs, wrs, mask;
        vector_t v;
        fd = $fopen("dv/instr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file dv/instr_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %d %d %d %d %d %d %d %h",
                                op, f3, f7, z, ng, c, ov, cls, pcs, wrs, mask);
                    if (n == 11) begin  // Header lines fall through
                        v.opcode = op[OPCODE_W-1:0];
                        v.funct3 = f3[FUNCT3_W-1:0];
                        v.funct7 = f7[FUNCT7_W-1:0];
                        v.flags  = {z[0], ng[0], c[0], ov[0]};
                        v.cls    = cls[3:0];
                        v.pc_src = pcs[0];
                        v.wr_src = wrs[WR_SRC_W-1:0];
                        v.mask   = mask[BYTE_EN_W-1:0];
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Counts cycles until a memory request is open
    task automatic wait_request(output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!(mem_rd_en || mem_wr_en));
    endtask

    task automatic delay_ack(input int idx, input logic [BYTE_EN_W-1:0] mask);
        int wait_cycles;
        wait_cycles = $urandom % 4;
        repeat (wait_cycles) begin
            @(negedge clock);
            if (ir_en !== 1'b0 || pc_en !== 1'b0 || wr_reg_en !== 1'b0)
                report_error(idx, "strobe raised before acknowledge");
            if (mem_byte_en !== mask) report_error(idx, "byte mask not held while waiting");
        end
        @(posedge clock);
        #1;
        mem_ack = 1'b1;
    endtask

    task automatic run_vector(input int idx, input vector_t v);
        int                  cycles;
        bit                  is_load;
        bit                  is_data;
        bit                  writes;
        bit                  alu_class;
        bit                  word_op;
        bit                  exp_sub;
        bit                  exp_arith;
        logic [ALU_OP_W-1:0] exp_alu_op;
        is_load   = (v.cls == CLASS_LOAD);
        is_data   = is_load || (v.cls == CLASS_STORE);
        writes    = v.cls inside {CLASS_REG_REG, CLASS_REG_IMM, CLASS_LUI, CLASS_AUIPC,
                                  CLASS_JAL, CLASS_JALR};
        alu_class = v.cls inside {CLASS_REG_REG, CLASS_REG_IMM};
        word_op   = alu_class && v.opcode[3];  // W forms carry opcode bit 3
        exp_sub   = (v.cls == CLASS_BRANCH) || (v.cls == CLASS_REG_REG && v.funct7[5]);
        exp_arith = (v.cls == CLASS_REG_REG && v.funct7[5]) ||
                    (v.cls == CLASS_REG_IMM && v.funct7[5] && v.funct3 == 3'b101);
        if (v.cls == CLASS_REG_REG)
            exp_alu_op = {v.funct7[0], v.funct3};
        else if (v.cls == CLASS_REG_IMM)
            exp_alu_op = {1'b0, v.funct3};
        else
            exp_alu_op = '0;

        wait_request(cycles);
        if (cycles != 2 || mem_rd_en !== 1'b1 || mem_byte_en !== 8'hFF || ir_en !== 1'b0)
            report_error(idx, "fetch read late or without full mask");
        delay_ack(idx, 8'hFF);
        opcode = v.opcode;  // Instruction word arrives with the fetch
        funct3 = v.funct3;
        funct7 = v.funct7;
        {zero, negative, carry_out, overflow} = v.flags;
        @(negedge clock);
        if (ir_en !== 1'b1 || pc_en !== 1'b0) report_error(idx, "ir_en missing on fetch ack");
        @(posedge clock);
        #1;
        mem_ack = 1'b0;
        @(negedge clock);  // DECODE
        if (ir_en !== 1'b0 || pc_en !== 1'b0 || mem_rd_en !== 1'b0)
            report_error(idx, "strobes active in DECODE");
        @(negedge clock);  // EXECUTE
        if (illegal_instruction !== (v.cls == CLASS_ILLEGAL))
            report_error(idx, "wrong illegal_instruction");
        if (ecall !== (v.cls == CLASS_ECALL)) report_error(idx, "wrong ecall");
        if (!is_data) begin
            if (pc_en !== 1'b1 || pc_src !== v.pc_src) report_error(idx, "wrong pc_en or pc_src");
            if (wr_reg_en !== writes || wr_reg_src !== v.wr_src)
                report_error(idx, "wrong register write strobes");
            if (alub_src !== (v.cls inside {CLASS_REG_IMM, CLASS_LUI, CLASS_AUIPC}))
                report_error(idx, "wrong alub_src");
            if (alua_src !== (v.cls == CLASS_AUIPC)) report_error(idx, "wrong alua_src");
            if (aluy_src !== (word_op || v.cls == CLASS_LUI)) report_error(idx, "wrong aluy_src");
            if (alupc_src !== (v.cls == CLASS_JALR)) report_error(idx, "wrong alupc_src");
            if (alu_src !== exp_alu_op) report_error(idx, "wrong ALU operation");
            if (sub !== exp_sub) report_error(idx, "wrong sub");
            if (arithmetic !== exp_arith) report_error(idx, "wrong arithmetic");
            if (mem_rd_en !== 1'b0 || mem_wr_en !== 1'b0 || mem_byte_en !== v.mask)
                report_error(idx, "memory active in EXECUTE");
        end else begin
            if (pc_en !== 1'b0 || wr_reg_en !== 1'b0 || mem_addr_src !== 1'b1)
                report_error(idx, "load or store completed in EXECUTE");
            wait_request(cycles);
            if (cycles != 1 || mem_rd_en !== is_load || mem_wr_en !== !is_load)
                report_error(idx, "wrong data request");
            if (mem_byte_en !== v.mask) report_error(idx, "wrong data byte mask");
            delay_ack(idx, v.mask);
            @(negedge clock);
            if (pc_en !== 1'b1 || wr_reg_en !== is_load || wr_reg_src !== v.wr_src)
                report_error(idx, "wrong strobes on data acknowledge");
            if (mem_addr_src !== 1'b1) report_error(idx, "address source dropped on acknowledge");
            if (mem_byte_en !== v.mask || pc_src !== v.pc_src)
                report_error(idx, "mask or pc_src changed on data acknowledge");
            @(posedge clock);
            #1;
            mem_ack = 1'b0;
        end
    endtask

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        mem_ack   = 1'b0;
        opcode    = '0;
        funct3    = '0;
        funct7    = '0;
        zero      = 1'b0;
        negative  = 1'b0;
        carry_out = 1'b0;
        overflow  = 1'b0;
        errors    = 0;
        loaded    = 1'b0;
        void'($urandom(31));
        load_stimulus();
        if (vectors.size() == 0) begin
            $display("No stimulus vectors were loaded");
            $display("TESTS FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            @(negedge clock);
            if (any_strobe() !== 1'b0) report_error(0, "strobes active during reset");
            repeat (2) @(posedge clock);
            #1;
            reset = 1'b0;
            @(negedge clock);
            if (any_strobe() !== 1'b0) report_error(0, "strobes active in IDLE");
            foreach (vectors[i]) run_vector(i, vectors[i]);
            $display("vectors %0d, errors %0d", vectors.size(), errors);
            if (errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat (vectors.size() * 20 + 10) @(posedge clock);
        $display("Watchdog timeout, simulation stopped before all vectors ran");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- logic/control_seq.sv
module control_seq (
    input  logic                             clock,
    input  logic                             reset,
    decode_if.consumer                       dec,
    mem_req_if.requester                     mem,
    output logic                             alua_src,
    output logic                             alub_src,
    output logic                             aluy_src,
    output logic [rv_ctrl_pkg::ALU_OP_W-1:0] alu_src,
    output logic                             sub,
    output logic                             arithmetic,
    output logic                             alupc_src,
    output logic                             pc_src,
    output logic                             pc_en,
    output logic [rv_ctrl_pkg::WR_SRC_W-1:0] wr_reg_src,
    output logic                             wr_reg_en,
    output logic                             ir_en,
    output logic                             mem_addr_src,
    output logic                             illegal_instruction,
    output logic                             ecall
);
    import rv_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        fetch_wait;  // MEM_WAIT belongs to a fetch
    logic        is_load;
    logic        is_store;
    logic        data_class;
    logic        data_phase;

    assign is_load    = (dec.instr_class == CLASS_LOAD);
    assign is_store   = (dec.instr_class == CLASS_STORE);
    assign data_class = is_load || is_store;
    assign data_phase = data_class &&
                        (state == EXECUTE || (state == MEM_WAIT && !fetch_wait));

    assign mem.start       = (state == FETCH) || (state == EXECUTE && data_class);
    assign mem.write       = (state == EXECUTE) && is_store;
    assign mem.data_access = (state == EXECUTE);
    assign mem.byte_en     = dec.byte_en;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            fetch_wait <= 1'b0;
        end else begin
            state <= next_state;
            if (state == FETCH) begin
                fetch_wait <= 1'b1;
            end else if (state == EXECUTE) begin
                fetch_wait <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state          = state;
        alua_src            = 1'b0;
        alub_src            = 1'b0;
        aluy_src            = 1'b0;
        alu_src             = '0;
        sub                 = 1'b0;
        arithmetic          = 1'b0;
        alupc_src           = 1'b0;
        pc_src              = 1'b0;
        pc_en               = 1'b0;
        wr_reg_src          = WR_SRC_ALU;
        wr_reg_en           = 1'b0;
        ir_en               = 1'b0;
        mem_addr_src        = 1'b0;
        illegal_instruction = 1'b0;
        ecall               = 1'b0;

        case (state)
            IDLE: next_state = FETCH;
            FETCH: next_state = MEM_WAIT;
            DECODE: next_state = EXECUTE;
            EXECUTE: begin
                pc_en      = !data_class;
                next_state = data_class ? MEM_WAIT : FETCH;
                case (dec.instr_class)
                    CLASS_REG_REG, CLASS_REG_IMM: begin
                        alub_src   = dec.imm_operand;
                        aluy_src   = dec.alu_word;
                        alu_src    = dec.alu_op;
                        sub        = dec.alu_sub;
                        arithmetic = dec.alu_arith;
                        wr_reg_en  = 1'b1;
                    end
                    CLASS_LUI: begin
                        alub_src  = 1'b1;
                        aluy_src  = 1'b1;
                        wr_reg_en = 1'b1;
                    end
                    CLASS_AUIPC: begin
                        alua_src  = 1'b1;
                        alub_src  = 1'b1;
                        wr_reg_en = 1'b1;
                    end
                    CLASS_JAL, CLASS_JALR: begin
                        alupc_src  = (dec.instr_class == CLASS_JALR);  // rs1-based target
                        pc_src     = 1'b1;
                        wr_reg_src = WR_SRC_LINK;
                        wr_reg_en  = 1'b1;
                    end
                    CLASS_BRANCH: begin
                        sub    = 1'b1;
                        pc_src = dec.take_branch;
                    end
                    CLASS_ECALL: ecall = 1'b1;
                    CLASS_ILLEGAL: illegal_instruction = 1'b1;
                    default: ;  // FENCE, load and store
                endcase
            end
            MEM_WAIT: begin
                if (fetch_wait) begin
                    ir_en = mem.done;
                    if (mem.done) next_state = DECODE;
                end else begin
                    pc_en     = mem.done;
                    wr_reg_en = mem.done && is_load;
                    if (mem.done) next_state = FETCH;
                end
            end
            default: next_state = IDLE;
        endcase

        // Address path held for the whole data access
        if (data_phase) begin
            mem_addr_src = 1'b1;
            alub_src     = dec.imm_operand;
            wr_reg_src   = is_load ? WR_SRC_MEM : WR_SRC_ALU;
        end
    end

    pc_ir_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(pc_en && ir_en)
    );

    // Each instruction ends back in FETCH
    exit_to_fetch: assert property (
        @(posedge clock) disable iff (reset)
        (pc_en || state == IDLE) |=> (state == FETCH)
    );

endmodule

//--- logic/ctrl_ifs.sv
interface decode_if;
    import rv_ctrl_pkg::*;

    instr_class_t           instr_class;
    logic [ALU_OP_W-1:0]    alu_op;
    logic                   alu_sub;
    logic                   alu_arith;
    logic                   alu_word;     // 32-bit W forms
    logic                   imm_operand;
    logic                   take_branch;
    logic [BYTE_EN_W-1:0]   byte_en;

    modport producer (output instr_class, alu_op, alu_sub, alu_arith, alu_word,
                      imm_operand, take_branch, byte_en);
    modport consumer (input instr_class, alu_op, alu_sub, alu_arith, alu_word,
                      imm_operand, take_branch, byte_en);
endinterface

interface mem_req_if;
    import rv_ctrl_pkg::*;

    logic                   start;
    logic                   write;
    logic                   data_access;  // Else full-word fetch
    logic [BYTE_EN_W-1:0]   byte_en;
    logic                   done;

    modport requester (output start, write, data_access, byte_en,
                       input done);
    modport responder (input start, write, data_access, byte_en,
                       output done);
endinterface

//--- logic/instr_decoder.sv
module instr_decoder (
    input  logic [rv_ctrl_pkg::OPCODE_W-1:0] opcode,
    input  logic [rv_ctrl_pkg::FUNCT3_W-1:0] funct3,
    input  logic [rv_ctrl_pkg::FUNCT7_W-1:0] funct7,
    input  logic                             zero,
    input  logic                             negative,
    input  logic                             carry_out,
    input  logic                             overflow,
    decode_if.producer                       dec
);
    import rv_ctrl_pkg::*;

    instr_class_t cls;
    logic         reg_form;
    logic         imm_form;
    logic         eq_ne;
    logic         lt_ge;
    logic         ltu_geu;

    assign reg_form = (opcode == OP_REG) || (opcode == OP_REG_W);
    assign imm_form = (opcode == OP_IMM) || (opcode == OP_IMM_W);

    // Classification and legality
    always_comb begin
        cls = CLASS_ILLEGAL;
        case (opcode)
            OP_REG: begin
                cls = CLASS_REG_REG;
                if (funct3 == 3'b000 || funct3 == 3'b101) begin
                    if ({funct7[6], funct7[4:1]} != '0) cls = CLASS_ILLEGAL;
                end else if (funct7[6:1] != '0) begin
                    cls = CLASS_ILLEGAL;
                end
            end
            OP_REG_W: begin
                cls = CLASS_REG_REG;
                if (funct3 == 3'b000 || funct3 == 3'b101) begin
                    if ({funct7[6], funct7[4:0]} != '0) cls = CLASS_ILLEGAL;
                end else if (funct3 != 3'b001) begin
                    cls = CLASS_ILLEGAL;
                end
            end
            OP_IMM: begin
                cls = CLASS_REG_IMM;
                if (funct3 == 3'b001 && funct7[6:1] != '0) cls = CLASS_ILLEGAL;
                if (funct3 == 3'b101 && {funct7[6], funct7[4:1]} != '0) cls = CLASS_ILLEGAL;
            end
            OP_IMM_W: begin
                cls = CLASS_REG_IMM;
                if (funct3 == 3'b101 && {funct7[6], funct7[4:0]} != '0) begin
                    cls = CLASS_ILLEGAL;  // SRLIW/SRAIW
                end else if (funct3 == 3'b001 && funct7 != '0) begin
                    cls = CLASS_ILLEGAL;  // SLLIW
                end else if (!(funct3 inside {3'b000, 3'b001, 3'b101})) begin
                    cls = CLASS_ILLEGAL;
                end
            end
            OP_LOAD: cls = (funct3 == 3'b111) ? CLASS_ILLEGAL : CLASS_LOAD;
            OP_STORE: cls = funct3[2] ? CLASS_ILLEGAL : CLASS_STORE;
            OP_BRANCH: cls = CLASS_BRANCH;
            OP_LUI: cls = CLASS_LUI;
            OP_AUIPC: cls = CLASS_AUIPC;
            OP_JAL: cls = CLASS_JAL;
            OP_JALR: cls = CLASS_JALR;
            OP_FENCE: cls = CLASS_FENCE;
            OP_SYSTEM: begin
                // Only ECALL without Zicsr or trap return
                if (funct3 == '0 && funct7 == '0) cls = CLASS_ECALL;
            end
            default: cls = CLASS_ILLEGAL;
        endcase
    end

    assign dec.instr_class = cls;

    // ALU controls
    assign dec.alu_op    = reg_form ? {funct7[0], funct3} :
                           imm_form ? {1'b0, funct3} : '0;
    assign dec.alu_sub   = reg_form && funct7[5];
    assign dec.alu_arith = reg_form ? funct7[5] :
                           (imm_form && funct7[5] && funct3 == 3'b101);  // SRAI only
    assign dec.alu_word  = (opcode == OP_REG_W) || (opcode == OP_IMM_W);
    assign dec.imm_operand = cls inside {CLASS_REG_IMM, CLASS_LUI, CLASS_AUIPC,
                                         CLASS_LOAD, CLASS_STORE};

    // Branch decision from subtraction flags
    assign eq_ne   = zero ^ funct3[0];
    assign lt_ge   = (negative ^ overflow) ^ funct3[0];
    assign ltu_geu = carry_out ~^ funct3[0];  // Carry set means no borrow
    assign dec.take_branch = funct3[1] ? ltu_geu : (funct3[2] ? lt_ge : eq_ne);

    always_comb begin
        case (funct3[1:0])
            2'b00:   dec.byte_en = 8'h01;
            2'b01:   dec.byte_en = 8'h03;
            2'b10:   dec.byte_en = 8'h0F;
            default: dec.byte_en = 8'hFF;
        endcase
    end

    always_comb begin
        assert (cls inside {[CLASS_REG_REG:CLASS_ILLEGAL]});
    end

endmodule

//--- logic/mem_access_seq.sv
module mem_access_seq (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              mem_ack,
    mem_req_if.responder                      req,
    output logic                              mem_rd_en,
    output logic                              mem_wr_en,
    output logic [rv_ctrl_pkg::BYTE_EN_W-1:0] mem_byte_en
);
    import rv_ctrl_pkg::*;

    logic req_open;

    assign req_open = mem_rd_en || mem_wr_en;

    // Same cycle as the acknowledge
    assign req.done = req_open && mem_ack;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mem_rd_en   <= 1'b0;
            mem_wr_en   <= 1'b0;
            mem_byte_en <= '0;
        end else if (req.start) begin
            mem_rd_en   <= !req.write;
            mem_wr_en   <= req.write;
            mem_byte_en <= req.data_access ? req.byte_en : {BYTE_EN_W{1'b1}};
        end else if (req.done) begin
            mem_rd_en   <= 1'b0;
            mem_wr_en   <= 1'b0;
            mem_byte_en <= '0;
        end
    end

    rd_wr_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(mem_rd_en && mem_wr_en)
    );

    // Requester must wait for done
    no_start_while_open: assert property (
        @(posedge clock) disable iff (reset)
        req.start |-> !req_open
    );

endmodule

//--- logic/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;
    localparam int BYTE_EN_W = 8;  // RV64 doubleword lanes
    localparam int ALU_OP_W  = 4;
    localparam int WR_SRC_W  = 2;

    // Base RV64I major opcodes
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_REG_W  = 7'b0111011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_IMM_W  = 7'b0011011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OP_FENCE  = 7'b0001111;
    localparam logic [OPCODE_W-1:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        CLASS_REG_REG = 4'd0,
        CLASS_REG_IMM = 4'd1,
        CLASS_LUI     = 4'd2,
        CLASS_AUIPC   = 4'd3,
        CLASS_JAL     = 4'd4,
        CLASS_JALR    = 4'd5,
        CLASS_BRANCH  = 4'd6,
        CLASS_LOAD    = 4'd7,
        CLASS_STORE   = 4'd8,
        CLASS_FENCE   = 4'd9,
        CLASS_ECALL   = 4'd10,
        CLASS_ILLEGAL = 4'd11
    } instr_class_t;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        FETCH    = 3'd1,
        DECODE   = 3'd2,
        EXECUTE  = 3'd3,
        MEM_WAIT = 3'd4
    } ctrl_state_t;

    // Register file write source
    localparam logic [WR_SRC_W-1:0] WR_SRC_ALU  = 2'b00;
    localparam logic [WR_SRC_W-1:0] WR_SRC_MEM  = 2'b10;
    localparam logic [WR_SRC_W-1:0] WR_SRC_LINK = 2'b11;  // pc + 4

endpackage

//--- logic/rv_ctrl_top.sv
module rv_ctrl_top (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              mem_ack,
    input  logic [rv_ctrl_pkg::OPCODE_W-1:0]  opcode,
    input  logic [rv_ctrl_pkg::FUNCT3_W-1:0]  funct3,
    input  logic [rv_ctrl_pkg::FUNCT7_W-1:0]  funct7,
    input  logic                              zero,
    input  logic                              negative,
    input  logic                              carry_out,
    input  logic                              overflow,
    output logic                              mem_rd_en,
    output logic                              mem_wr_en,
    output logic [rv_ctrl_pkg::BYTE_EN_W-1:0] mem_byte_en,
    output logic                              alua_src,
    output logic                              alub_src,
    output logic                              aluy_src,
    output logic [rv_ctrl_pkg::ALU_OP_W-1:0]  alu_src,
    output logic                              sub,
    output logic                              arithmetic,
    output logic                              alupc_src,
    output logic                              pc_src,
    output logic                              pc_en,
    output logic [rv_ctrl_pkg::WR_SRC_W-1:0]  wr_reg_src,
    output logic                              wr_reg_en,
    output logic                              ir_en,
    output logic                              mem_addr_src,
    output logic                              illegal_instruction,
    output logic                              ecall
);

    decode_if  dec_bus ();
    mem_req_if mem_bus ();

    instr_decoder u_decoder (
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7    (funct7),
        .zero      (zero),
        .negative  (negative),
        .carry_out (carry_out),
        .overflow  (overflow),
        .dec       (dec_bus.producer)
    );

    mem_access_seq u_mem_seq (
        .clock       (clock),
        .reset       (reset),
        .mem_ack     (mem_ack),
        .req         (mem_bus.responder),
        .mem_rd_en   (mem_rd_en),
        .mem_wr_en   (mem_wr_en),
        .mem_byte_en (mem_byte_en)
    );

    control_seq u_ctrl_seq (
        .clock               (clock),
        .reset               (reset),
        .dec                 (dec_bus.consumer),
        .mem                 (mem_bus.requester),
        .alua_src            (alua_src),
        .alub_src            (alub_src),
        .aluy_src            (aluy_src),
        .alu_src             (alu_src),
        .sub                 (sub),
        .arithmetic          (arithmetic),
        .alupc_src           (alupc_src),
        .pc_src              (pc_src),
        .pc_en               (pc_en),
        .wr_reg_src          (wr_reg_src),
        .wr_reg_en           (wr_reg_en),
        .ir_en               (ir_en),
        .mem_addr_src        (mem_addr_src),
        .illegal_instruction (illegal_instruction),
        .ecall               (ecall)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert -j 0 --top-module rv_ctrl_tb -f src.f &&
./obj_dir/Vrv_ctrl_tb > sim.log 2>&1 ||
echo "Simulation build or run returned an error"
grep -q "^TESTS PASSED$" sim.log

//--- src.f
logic/rv_ctrl_pkg.sv
logic/ctrl_ifs.sv
logic/instr_decoder.sv
logic/mem_access_seq.sv
logic/control_seq.sv
logic/rv_ctrl_top.sv
dv/rv_ctrl_tb.sv
